/* dv/vic_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_arbiter_assert (
   input wire logic clk_dot4x,
   input wire logic rst,
   input wire logic clk_phi,
   input wire logic aec,
   input wire logic vic_write_db,
   input wire logic vic_write_ab,
   input wire logic ls245_dir
);

   // cpu only gets the bus in the tick after phi was high
   aec_follows_phi: assert property (@(posedge clk_dot4x) disable iff (rst)
      aec |-> $past(clk_phi))
      else $error("aec high without phi high one tick earlier");

   // data buffer direction mirrors the read drive
   dir_inverse: assert property (@(posedge clk_dot4x) disable iff (rst)
      ls245_dir == !vic_write_db)
      else $error("ls245_dir not the inverse of vic_write_db");

   // address buffer driven by the vic whenever the cpu lacks the bus
   ab_inverse: assert property (@(posedge clk_dot4x) disable iff (rst)
      vic_write_ab == !aec)
      else $error("vic_write_ab not the inverse of aec");

endmodule

bind vic_bus_arbiter vic_arbiter_assert u_arbiter_assert (.*);

`default_nettype wire

/* dv/vic_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_tb;

   localparam int LIM_PHASE = 200;
   localparam int LIM_LINE = 5000;
   localparam int LIM_FRAME = 700000;

   logic       clk_dot4x;
   logic       rst;
   logic       ce;
   logic       rw;
   logic [5:0] adi;
   logic [7:0] dbi;
   logic       clk_phi;
   logic [9:0] raster_x;
   logic [8:0] raster_line;
   logic [7:0] dbo;
   logic       irq;
   logic       ba;
   logic       aec;
   logic       vic_write_db;
   logic       vic_write_ab;
   logic       ls245_dir;
   int         errors;
   logic [31:0] rng;

   vic_core #(.chip(vic_timing_pkg::CHIP6567R8)) DUT (
      .clk_dot4x(clk_dot4x), .rst(rst), .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
      .clk_phi(clk_phi), .raster_x(raster_x), .raster_line(raster_line), .dbo(dbo),
      .irq(irq), .ba(ba), .aec(aec), .vic_write_db(vic_write_db),
      .vic_write_ab(vic_write_ab), .ls245_dir(ls245_dir)
   );

   // 20 ns dot4x period
   always #10 clk_dot4x = ~clk_dot4x;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // expected ba from line, x, the den state seen at line 48 and yscroll
   function automatic int exp_ba(input int line, input int x, input bit allow, input int ys);
      bit bad;
      int cyc;
      bad = allow && line >= int'(vic_timing_pkg::BADLINE_FIRST_LINE) &&
            line < int'(vic_timing_pkg::BADLINE_END_LINE) && (line % 8) == ys;
      cyc = x / 8;
      if (bad && cyc >= int'(vic_timing_pkg::CHARS_BA_FIRST_CYCLE) &&
          cyc <= int'(vic_timing_pkg::CHARS_BA_LAST_CYCLE))
         return 0;
      return 1;
   endfunction

   // expected cpu read value, unused bits of $19 and $1a read 1
   function automatic int exp_read(input int addr, input int ctrl_w, input int line,
                                   input int irst, input int erst);
      case (addr)
         int'(vic_regs_pkg::REG_CTRL1):      return (ctrl_w & 'h7f) | (((line >> 8) & 1) << 7);
         int'(vic_regs_pkg::REG_RASTER):     return line & 'hff;
         int'(vic_regs_pkg::REG_IRQ_STATUS): return 'h7e | irst | ((irst & erst) << 7);
         int'(vic_regs_pkg::REG_IRQ_ENABLE): return 'hfe | erst;
         default:                            return 'hff;
      endcase
   endfunction

   task automatic check_val(input string name, input int got, input int exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "value check failed");
      end
   endtask

   // one falling edge of a bounded wait
   task automatic tick(inout int n, input int limit, input string what);
      @(negedge clk_dot4x);
      n++;
      if (n > limit) begin
         $display("timeout while waiting for %s", what);
         $display("RESULT: FAIL");
         $fatal(1, "wait timed out");
      end
   endtask

   // write lands on the end of the phi high phase
   task automatic cpu_write(input logic [5:0] a, input logic [7:0] d, input logic ce_v);
      int n;
      n = 0;
      while (!clk_phi) tick(n, LIM_PHASE, "phi high before a write");
      ce = ce_v;
      rw = 1'b0;
      adi = a;
      dbi = d;
      n = 0;
      while (clk_phi) tick(n, LIM_PHASE, "phi low after a write");
      ce = 1'b1;
      rw = 1'b1;
   endtask

   task automatic cpu_read(input logic [5:0] a, output int data);
      adi = a;
      ce = 1'b0;
      rw = 1'b1;
      @(negedge clk_dot4x);
      @(negedge clk_dot4x);
      data = int'(dbo);
      ce = 1'b1;
   endtask

   // stay clear of the lag between raster_line and its phi-aligned copy
   task automatic wait_mid_line();
      int n;
      n = 0;
      while (raster_x < 16 || raster_x > 480) tick(n, LIM_LINE, "middle of a line");
   endtask

   // checks ba, buffer steering and the aec cascade until last_line begins
   task automatic monitor_bus(input bit allow, input int ys, input int last_line,
                              output int badlines);
      int n;
      int rises;
      bit ba_prev;
      bit aec_prev;
      bit wdb_exp;
      n = 0;
      rises = 0;
      badlines = 0;
      // unmapped address, so cpu writes here change nothing
      adi = 6'h3f;
      ce = 1'b0;
      rw = 1'b1;
      tick(n, LIM_FRAME, "end of the bus monitor window");
      ba_prev = 1'b1;
      aec_prev = aec;
      while (int'(raster_line) != last_line) begin
         check_val("ba", int'(ba), exp_ba(int'(raster_line), int'(raster_x), allow, ys));
         // buffer drives the cpu side only for a selected read while the cpu owns the bus
         wdb_exp = aec && rw && !ce;
         check_val("vic_write_db", int'(vic_write_db), int'(wdb_exp));
         check_val("ls245_dir", int'(ls245_dir), int'(!wdb_exp));
         check_val("vic_write_ab", int'(vic_write_ab), int'(!aec));
         if (!ba && ba_prev) begin
            badlines++;
            rises = 0;
         end
         if (!ba && aec && !aec_prev) rises++;
         // cpu keeps exactly three phi high phases after ba falls
         if (ba && !ba_prev) check_val("aec_phases", rises, 3);
         ba_prev = ba;
         aec_prev = aec;
         // mix of reads, writes and deselected ticks
         rw = (n % 3) != 0;
         ce = (n % 5) == 0;
         tick(n, LIM_FRAME, "end of the bus monitor window");
      end
      ce = 1'b1;
      rw = 1'b1;
   endtask

   initial begin
      int n;
      int cnt;
      int x0;
      int rd;
      int cmp;
      int cmp2;
      int ys;
      int bl;
      clk_dot4x = 1'b0;
      rst = 1'b1;
      ce = 1'b1;
      rw = 1'b1;
      adi = '0;
      dbi = '0;
      errors = 0;
      rng = 32'h4826;
      repeat (3) @(negedge clk_dot4x);
      rst = 1'b0;

      // phi 16 high, 16 low
      n = 0;
      while (!clk_phi) tick(n, LIM_PHASE, "phi rise");
      cnt = 0;
      while (clk_phi) tick(cnt, LIM_PHASE, "phi fall");
      check_val("phi_high_ticks", cnt, 16);
      cnt = 0;
      while (!clk_phi) tick(cnt, LIM_PHASE, "phi rise");
      check_val("phi_low_ticks", cnt, 16);

      // one dot every 4 ticks, line wraps after x 519
      x0 = int'(raster_x);
      n = 0;
      while (int'(raster_x) == x0) tick(n, LIM_PHASE, "raster_x step");
      x0 = int'(raster_x);
      cnt = 0;
      while (int'(raster_x) == x0) tick(cnt, LIM_PHASE, "raster_x step");
      check_val("dot_ticks", cnt, 4);
      n = 0;
      while (raster_x != 10'd519) tick(n, LIM_LINE, "raster_x 519");
      n = 0;
      while (raster_x == 10'd519) tick(n, LIM_PHASE, "raster_x wrap");
      check_val("raster_x", int'(raster_x), 0);
      check_val("raster_line", int'(raster_line), 1);

      // register readback
      cpu_write(vic_regs_pkg::REG_CTRL1, 8'h6b, 1'b0);
      wait_mid_line();
      cpu_read(vic_regs_pkg::REG_CTRL1, rd);
      check_val("rd_ctrl1", rd, exp_read('h11, 'h6b, int'(raster_line), 0, 0));
      cpu_write(vic_regs_pkg::REG_CTRL1, 8'h15, 1'b1);
      cpu_read(vic_regs_pkg::REG_CTRL1, rd);
      check_val("rd_ctrl1_blocked", rd, exp_read('h11, 'h6b, int'(raster_line), 0, 0));
      wait_mid_line();
      cpu_read(vic_regs_pkg::REG_RASTER, rd);
      check_val("rd_raster", rd, exp_read('h12, 'h6b, int'(raster_line), 0, 0));
      cpu_read(6'h20, rd);
      check_val("rd_unmapped", rd, exp_read('h20, 'h6b, int'(raster_line), 0, 0));

      // raster irq with enable set
      rng = lcg_next(rng);
      cmp = 4 + int'(rng[23:16] % 8'd24);
      cpu_write(vic_regs_pkg::REG_CTRL1, 8'h00, 1'b0);
      cpu_write(vic_regs_pkg::REG_RASTER, 8'(cmp), 1'b0);
      // compare value 0 matched line 0 after reset and left the latch set
      cpu_write(vic_regs_pkg::REG_IRQ_STATUS, 8'h01, 1'b0);
      cpu_write(vic_regs_pkg::REG_IRQ_ENABLE, 8'h01, 1'b0);
      n = 0;
      while (!irq) tick(n, LIM_FRAME, "raster irq");
      check_val("irq_line", int'(raster_line), cmp);
      cpu_write(vic_regs_pkg::REG_IRQ_STATUS, 8'h01, 1'b0);
      check_val("irq_after_ack", int'(irq), 0);
      n = 0;
      while (int'(raster_line) == cmp) begin
         check_val("irq_same_line", int'(irq), 0);
         tick(n, LIM_LINE, "end of the compare line");
      end

      // latch still sets with the enable clear
      cmp2 = cmp + 3;
      cpu_write(vic_regs_pkg::REG_IRQ_ENABLE, 8'h00, 1'b0);
      cpu_write(vic_regs_pkg::REG_RASTER, 8'(cmp2), 1'b0);
      n = 0;
      while (int'(raster_line) != cmp2 || raster_x < 10'd200) begin
         check_val("irq_disabled", int'(irq), 0);
         tick(n, LIM_FRAME, "second compare line");
      end
      cpu_read(vic_regs_pkg::REG_IRQ_STATUS, rd);
      check_val("rd_irq_status", rd, exp_read('h19, 0, 0, 1, 0));
      cpu_write(vic_regs_pkg::REG_IRQ_STATUS, 8'h01, 1'b0);
      cpu_read(vic_regs_pkg::REG_IRQ_STATUS, rd);
      check_val("rd_irq_status_ack", rd, exp_read('h19, 0, 0, 0, 0));

      // badlines with den set before line 48
      rng = lcg_next(rng);
      ys = int'(rng[18:16]);
      cpu_write(vic_regs_pkg::REG_CTRL1, 8'h10 | 8'(ys), 1'b0);
      monitor_bus(1'b1, ys, 64, bl);
      check_val("badline_count", bl, 2);

      // den clear at line 48 of the next frame
      cpu_write(vic_regs_pkg::REG_CTRL1, 8'(ys), 1'b0);
      n = 0;
      while (raster_line != 9'd262) tick(n, LIM_FRAME, "raster line 262");
      n = 0;
      while (raster_line == 9'd262) tick(n, LIM_LINE, "frame wrap");
      check_val("raster_line_wrap", int'(raster_line), 0);
      monitor_bus(1'b0, ys, 64, bl);
      check_val("badline_count_den_off", bl, 0);

      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/vic_bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_bus_arbiter (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  logic                 clk_phi,
   input  logic                 phase_start_high,
   input  logic                 phase_end_high,
   input  logic                 ce,
   input  logic                 rw,
   input  logic [8:0]           raster_line_d,
   input  logic [6:0]           cycle_num,
   input  vic_regs_pkg::ctrl1_u ctrl1,
   output logic                 ba,
   output logic                 aec,
   output logic                 vic_write_db,
   output logic                 vic_write_ab,
   output logic                 ls245_dir
);

   logic       allow_bad_lines;
   logic [2:0] yscroll_q;
   logic       badline;
   // ba delayed through three phi high phases
   logic       ba1;
   logic       ba2;
   logic       ba3;

   // den only counts on line 48, window closes on line 248
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
         yscroll_q <= '0;
      end else if (phase_start_high) begin
         yscroll_q <= ctrl1.f.yscroll;
         if (raster_line_d == vic_timing_pkg::BADLINE_FIRST_LINE && ctrl1.f.den) begin
            allow_bad_lines <= 1'b1;
         end
         if (raster_line_d == vic_timing_pkg::BADLINE_END_LINE) begin
            allow_bad_lines <= 1'b0;
         end
      end
   end

   assign badline = allow_bad_lines &&
                    (raster_line_d >= vic_timing_pkg::BADLINE_FIRST_LINE) &&
                    (raster_line_d < vic_timing_pkg::BADLINE_END_LINE) &&
                    (raster_line_d[2:0] == yscroll_q);

   // character fetch window pulls ba low
   assign ba = !(badline &&
                 (cycle_num >= vic_timing_pkg::CHARS_BA_FIRST_CYCLE) &&
                 (cycle_num <= vic_timing_pkg::CHARS_BA_LAST_CYCLE));

   // a rising ba releases every stage at once
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (phase_end_high) begin
         ba1 <= ba;
         ba2 <= ba1 | ba;
         ba3 <= ba2 | ba;
      end
   end

   // cpu owns the bus in phi high unless the cascade has run out
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec <= 1'b0;
      end else begin
         aec <= ba ? clk_phi : (ba3 & clk_phi);
      end
   end

   // LS245 steering, DIR low drives the cpu side
   assign vic_write_db = aec & rw & ~ce;
   assign vic_write_ab = ~aec;
   assign ls245_dir = ~vic_write_db;

endmodule

`default_nettype wire

/* hw/vic_core.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_core #(
   parameter vic_timing_pkg::chip_type chip = vic_timing_pkg::CHIP6567R8
) (
   input  logic                    clk_dot4x,
   input  logic                    rst,
   input  logic                    ce,
   input  logic                    rw,
   input  vic_regs_pkg::reg_addr_t adi,
   input  logic [7:0]              dbi,
   output logic                    clk_phi,
   output logic [9:0]              raster_x,
   output logic [8:0]              raster_line,
   output logic [7:0]              dbo,
   output logic                    irq,
   output logic                    ba,
   output logic                    aec,
   output logic                    vic_write_db,
   output logic                    vic_write_ab,
   output logic                    ls245_dir
);

   // phase markers
   logic                 phase_start_high;
   logic                 phase_end_high;
   logic                 dot_tick;
   // beam position shared by irq and badline logic
   logic [8:0]           raster_line_d;
   logic [6:0]           cycle_num;
   vic_regs_pkg::ctrl1_u ctrl1;

   vic_phase_gen u_phase_gen (
      .clk_dot4x(clk_dot4x), .rst(rst), .clk_phi(clk_phi),
      .phase_start_high(phase_start_high), .phase_start_low(),
      .phase_end_high(phase_end_high), .dot_tick(dot_tick)
   );

   vic_raster #(.chip(chip)) u_raster (
      .clk_dot4x(clk_dot4x), .rst(rst), .dot_tick(dot_tick),
      .phase_start_high(phase_start_high), .raster_x(raster_x),
      .raster_line(raster_line), .raster_line_d(raster_line_d), .cycle_num(cycle_num)
   );

   vic_registers u_registers (
      .clk_dot4x(clk_dot4x), .rst(rst), .clk_phi(clk_phi),
      .phase_start_high(phase_start_high), .phase_end_high(phase_end_high),
      .ce(ce), .rw(rw), .adi(adi), .dbi(dbi), .raster_line_d(raster_line_d),
      .dbo(dbo), .ctrl1(ctrl1), .irq(irq)
   );

   vic_bus_arbiter u_bus_arbiter (
      .clk_dot4x(clk_dot4x), .rst(rst), .clk_phi(clk_phi),
      .phase_start_high(phase_start_high), .phase_end_high(phase_end_high),
      .ce(ce), .rw(rw), .raster_line_d(raster_line_d), .cycle_num(cycle_num),
      .ctrl1(ctrl1), .ba(ba), .aec(aec), .vic_write_db(vic_write_db),
      .vic_write_ab(vic_write_ab), .ls245_dir(ls245_dir)
   );

endmodule

`default_nettype wire

/* hw/vic_phase_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_phase_gen (
   input  logic clk_dot4x,
   input  logic rst,
   output logic clk_phi,
   output logic phase_start_high,
   output logic phase_start_low,
   output logic phase_end_high,
   output logic dot_tick
);

   // ticks in one phi half period
   localparam int HALF_TICKS = vic_timing_pkg::PHI_TICKS / 2;

   // one-hot position within the current phi phase, bit 0 is the first tick
   logic [HALF_TICKS-1:0] phase_ring;
   // one-hot position within a dot, bit 3 is the fourth tick and marks the dot edge
   logic [3:0]            dot_ring;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase_ring <= HALF_TICKS'(1);
         dot_ring <= 4'b0001;
         // reset state is the first tick of a low phase
         clk_phi <= 1'b0;
      end else begin
         phase_ring <= {phase_ring[HALF_TICKS-2:0], phase_ring[HALF_TICKS-1]};
         dot_ring <= {dot_ring[2:0], dot_ring[3]};
         // flip phi after the last tick of each phase
         if (phase_ring[HALF_TICKS-1]) begin
            clk_phi <= ~clk_phi;
         end
      end
   end

   // markers split by the phi level
   assign phase_start_high = clk_phi & phase_ring[0];
   assign phase_start_low = ~clk_phi & phase_ring[0];
   assign phase_end_high = clk_phi & phase_ring[HALF_TICKS-1];
   // every fourth tick, so each 8 dot cycle begins with phi low
   assign dot_tick = dot_ring[3];

endmodule

`default_nettype wire

/* hw/vic_raster.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_raster #(
   parameter vic_timing_pkg::chip_type chip = vic_timing_pkg::CHIP6567R8
) (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  logic       dot_tick,
   input  logic       phase_start_high,
   output logic [9:0] raster_x,
   output logic [8:0] raster_line,
   output logic [8:0] raster_line_d,
   output logic [6:0] cycle_num
);

   // beam limits for this variant
   localparam logic [9:0] X_MAX = vic_timing_pkg::raster_x_max(chip);
   localparam logic [8:0] Y_MAX = vic_timing_pkg::raster_y_max(chip);

   // end of line reached on this dot
   logic x_wrap;

   assign x_wrap = (raster_x == X_MAX);

   // horizontal counter, one step per dot
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x <= '0;
      end else if (dot_tick) begin
         raster_x <= x_wrap ? 10'd0 : raster_x + 10'd1;
      end
   end

   // line counter moves when x wraps
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line <= '0;
      end else if (dot_tick && x_wrap) begin
         if (raster_line == Y_MAX) begin
            raster_line <= '0;
         end else begin
            raster_line <= raster_line + 9'd1;
         end
      end
   end

   // line as seen at the start of the cpu phase
   // irq and badline logic compare against this copy
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line_d <= '0;
      end else if (phase_start_high) begin
         raster_line_d <= raster_line;
      end
   end

   // 8 dots per cycle
   assign cycle_num = raster_x[9:3];

endmodule

`default_nettype wire

/* hw/vic_registers.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_registers (
   input  logic                    clk_dot4x,
   input  logic                    rst,
   input  logic                    clk_phi,
   input  logic                    phase_start_high,
   input  logic                    phase_end_high,
   input  logic                    ce,
   input  logic                    rw,
   input  vic_regs_pkg::reg_addr_t adi,
   input  logic [7:0]              dbi,
   input  logic [8:0]              raster_line_d,
   output logic [7:0]              dbo,
   output vic_regs_pkg::ctrl1_u    ctrl1,
   output logic                    irq
);

   // low byte of the raster compare, bit 8 lives in ctrl1.raster8
   logic [7:0]           raster_lo;
   logic [8:0]           raster_cmp;
   // raster irq latch and enable
   logic                 irst;
   logic                 erst;
   // set once the compare has fired on the current line
   logic                 irq_fired;
   logic                 wr_en;
   logic                 irst_clr;
   logic [7:0]           rd_data;
   vic_regs_pkg::ctrl1_u ctrl1_rd;

   // cpu write lands at the end of the phi high half
   assign wr_en = clk_phi & phase_end_high & ~ce & ~rw;
   assign irst_clr = wr_en && (adi == vic_regs_pkg::REG_IRQ_STATUS) &&
                     dbi[vic_regs_pkg::IRQ_RST_BIT];
   assign raster_cmp = {ctrl1.f.raster8, raster_lo};

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1.raw <= '0;
         raster_lo <= '0;
         erst <= 1'b0;
      end else if (wr_en) begin
         case (adi)
            vic_regs_pkg::REG_CTRL1:      ctrl1.raw <= dbi;
            vic_regs_pkg::REG_RASTER:     raster_lo <= dbi;
            vic_regs_pkg::REG_IRQ_ENABLE: erst <= dbi[vic_regs_pkg::IRQ_RST_BIT];
            default:                      ;
         endcase
      end
   end

   // raster irq fires once per matching line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst <= 1'b0;
         irq_fired <= 1'b0;
      end else begin
         if (phase_start_high) begin
            if (raster_line_d == raster_cmp) begin
               if (!irq_fired) begin
                  irst <= 1'b1;
                  irq_fired <= 1'b1;
               end
            end else begin
               // line moved on, arm for the next match
               irq_fired <= 1'b0;
            end
         end
         // writing 1 acknowledges the latch
         if (irst_clr) begin
            irst <= 1'b0;
         end
      end
   end

   // latch is kept even while disabled
   assign irq = irst & erst;

   // read mux, unused bits read as 1
   always_comb begin
      ctrl1_rd = ctrl1;
      // readback shows the beam line, not the compare
      ctrl1_rd.f.raster8 = raster_line_d[8];
      rd_data = vic_regs_pkg::UNMAPPED_READ;
      case (adi)
         vic_regs_pkg::REG_CTRL1:  rd_data = ctrl1_rd.raw;
         vic_regs_pkg::REG_RASTER: rd_data = raster_line_d[7:0];
         vic_regs_pkg::REG_IRQ_STATUS: begin
            rd_data[vic_regs_pkg::IRQ_RST_BIT] = irst;
            rd_data[vic_regs_pkg::IRQ_ANY_BIT] = irq;
         end
         vic_regs_pkg::REG_IRQ_ENABLE: rd_data[vic_regs_pkg::IRQ_RST_BIT] = erst;
         default: rd_data = vic_regs_pkg::UNMAPPED_READ;
      endcase
   end

   // dbo follows adi one tick later
   always_ff @(posedge clk_dot4x) begin
      dbo <= rd_data;
   end

endmodule

`default_nettype wire

/* hw/vic_regs_pkg.sv */
`default_nettype none

package vic_regs_pkg;

   // 6-bit cpu register address
   typedef logic [5:0] reg_addr_t;

   // register map subset
   localparam reg_addr_t REG_CTRL1 = 6'h11;
   localparam reg_addr_t REG_RASTER = 6'h12;
   localparam reg_addr_t REG_IRQ_STATUS = 6'h19;
   localparam reg_addr_t REG_IRQ_ENABLE = 6'h1a;

   // control 1 layout, msb first
   typedef struct packed {
      // bit 8 of the raster compare on write, of the beam line on read
      logic       raster8;
      logic       ecm;
      logic       bmm;
      logic       den;
      logic       rsel;
      logic [2:0] yscroll;
   } ctrl1_fields_t;

   // the cpu sees a raw byte, the fetch logic sees the fields
   typedef union packed {
      logic [7:0]    raw;
      ctrl1_fields_t f;
   } ctrl1_u;

   // bit positions in $19 and $1a
   localparam int IRQ_RST_BIT = 0;
   localparam int IRQ_ANY_BIT = 7;

   // value returned for addresses outside the kept subset
   localparam logic [7:0] UNMAPPED_READ = 8'hff;

endpackage

`default_nettype wire

/* hw/vic_timing_pkg.sv */
`default_nettype none

package vic_timing_pkg;

   // supported chip variants
   typedef enum logic [1:0] {
      CHIP6567R8,
      CHIP6567R56A,
      CHIP6569
   } chip_type;

   // last raster_x value on a line, one dot per count
   function automatic logic [9:0] raster_x_max(input chip_type chip);
      case (chip)
         CHIP6567R8:   return 10'd519;
         CHIP6567R56A: return 10'd511;
         default:      return 10'd503;
      endcase
   endfunction

   // last raster line of a frame
   function automatic logic [8:0] raster_y_max(input chip_type chip);
      case (chip)
         CHIP6567R8:   return 9'd262;
         CHIP6567R56A: return 9'd261;
         default:      return 9'd311;
      endcase
   endfunction

   // badlines are possible from the first line up to but not including the end line
   localparam logic [8:0] BADLINE_FIRST_LINE = 9'd48;
   localparam logic [8:0] BADLINE_END_LINE = 9'd248;

   // ba low window for character fetches, inclusive cycle numbers
   localparam logic [6:0] CHARS_BA_FIRST_CYCLE = 7'd12;
   localparam logic [6:0] CHARS_BA_LAST_CYCLE = 7'd54;

   // dot4x ticks in one phi period
   localparam int PHI_TICKS = 32;

endpackage

`default_nettype wire

/* project.f */
hw/vic_timing_pkg.sv
hw/vic_regs_pkg.sv
hw/vic_phase_gen.sv
hw/vic_raster.sv
hw/vic_registers.sv
hw/vic_bus_arbiter.sv
hw/vic_core.sv
dv/vic_assert.sv
dv/vic_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module vic_tb -o vic_sim || exit 1
out=$(./obj_dir/vic_sim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1
